// File: bench/pipeline_input.txt
// word 0: entry count, then one entry per line
// valid inst | expected commit: wr_en rd data status (0 ok, 1 illegal, 2 wfi)
0000001c
1 00500093 1 01 00000005 0
1 ffd00113 1 02 fffffffd 0
1 123451b7 1 03 12345000 0
1 7f004213 1 04 000007f0 0
1 002082b3 1 05 00000002 0
1 40128333 1 06 fffffffd 0
1 0032c3b3 1 07 12345002 0
1 0063f433 1 08 12345000 0
1 001264b3 1 09 000007f5 0
1 0f04f513 1 0a 000000f0 0
1 f0056593 1 0b fffffff0 0
1 00708013 0 00 00000000 0
1 00b00633 1 0c fffffff0 0
0 06300693 0 00 00000000 0
1 00160693 1 0d fffffff1 0
0 00000013 0 00 00000000 0
0 00000013 0 00 00000000 0
1 40c68733 1 0e 00000001 0
1 0010a793 0 00 00000000 1
1 ffffffff 0 00 00000000 1
1 00e707b3 1 0f 00000002 0
1 00e7c833 1 10 00000003 0
1 00100a13 1 14 00000001 0
1 00200a13 1 14 00000002 0
1 014a0ab3 1 15 00000004 0
1 10500073 0 00 00000000 2
1 00100893 0 00 00000000 0
1 00108933 0 00 00000000 0

// File: pipeline_core.f
hdl/core_pkg.sv
hdl/regfile.sv
hdl/decoder.sv
hdl/forwarding_unit.sv
hdl/ex_stage.sv
hdl/pipeline_core.sv
bench/pipeline_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with verilator and run it from the project root
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --timescale 1ns/10ps \
        --top-module pipeline_core_tb -f pipeline_core.f \
        -o pipeline_core_sim \
    && ./obj_dir/pipeline_core_sim \
    || { echo "run_sim: build or run returned an error"; exit 1; }

// File: bench/pipeline_core_tb.sv
// rv32i pipeline testbench

`timescale 1ns/10ps

module pipeline_core_tb;
    import core_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int MAX_ENTRIES     = 64;
    localparam int WORDS_PER_ENTRY = 6;
    // word 0 of the file is the entry count
    localparam int STIM_WORDS      = 1 + MAX_ENTRIES * WORDS_PER_ENTRY;
    // issue edge to commit is three edges, plus one to settle
    localparam int DRAIN_CYCLES    = 4;

    // one expected retirement
    typedef struct packed {
        logic            wr_en;
        reg_idx_t        idx;
        xlen_t           data;
        exception_code_t status;
    } commit_t;

    logic            clk = 1'b0;
    logic            rst;
    logic            inst_valid;
    xlen_t           inst;
    logic            commit_wr_en;
    reg_idx_t        commit_wr_idx;
    xlen_t           commit_wr_data;
    logic            pipeline_completed_insts;
    exception_code_t pipeline_error_status;

    logic [31:0] stim_words [0:STIM_WORDS-1];
    int          n_entries = 0;
    int          n_commits = 0;
    commit_t     expected_q [$];

    pipeline_core i_dut (
        .clk                      (clk),
        .rst                      (rst),
        .inst_valid               (inst_valid),
        .inst                     (inst),
        .commit_wr_en             (commit_wr_en),
        .commit_wr_idx            (commit_wr_idx),
        .commit_wr_data           (commit_wr_data),
        .pipeline_completed_insts (pipeline_completed_insts),
        .pipeline_error_status    (pipeline_error_status)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ////////////////////
    // failure exits
    // ////////////////////

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0d ns: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "commit output mismatch");
    endtask

    task automatic stop_run(input string msg);
        $display("Simulation failed");
        $fatal(1, "%s", msg);
    endtask

    // ////////////////////
    // stimulus
    // ////////////////////

    initial begin
        int      base;
        commit_t exp;
        logic    halt_issued;
        halt_issued = 1'b0;
        rst         = 1'b1;
        inst_valid  = 1'b0;
        inst        = NOP_INST;
        $readmemh("bench/pipeline_input.txt", stim_words);
        n_entries = int'(stim_words[0]);
        assert (n_entries > 0 && n_entries <= MAX_ENTRIES)
        else stop_run("stimulus file entry count is missing or out of range");

        repeat (4) @(posedge clk);
        rst <= 1'b0;

        for (int e = 0; e < n_entries; e++) begin
            base = 1 + e * WORDS_PER_ENTRY;
            @(posedge clk);
            inst_valid <= stim_words[base][0];
            inst       <= stim_words[base + 1];
            // nothing after the wfi may retire
            if (stim_words[base][0] && !halt_issued) begin
                exp.wr_en  = stim_words[base + 2][0];
                exp.idx    = stim_words[base + 3][4:0];
                exp.data   = stim_words[base + 4];
                exp.status = stim_words[base + 5][1:0];
                expected_q.push_back(exp);
                if (exp.status == HALTED_ON_WFI)
                    halt_issued = 1'b1;
            end
        end

        @(posedge clk);
        inst_valid <= 1'b0;
        inst       <= NOP_INST;
        repeat (DRAIN_CYCLES) @(posedge clk);

        if (expected_q.size() == 0) begin
            $display("Simulation completed successfully");
            $finish;
        end else begin
            stop_run($sformatf("%0d expected commits never appeared", expected_q.size()));
        end
    end

    // ////////////////////
    // commit checks
    // ////////////////////

    task automatic check_commit();
        commit_t exp;
        assert (expected_q.size() != 0)
        else stop_run("an instruction committed with none outstanding");
        exp = expected_q.pop_front();
        assert (commit_wr_en == exp.wr_en)
        else report_mismatch($sformatf("commit %0d write flag %0b, expected %0b",
                                       n_commits, commit_wr_en, exp.wr_en));
        // index and data only matter on a real write
        if (exp.wr_en) begin
            assert (commit_wr_idx == exp.idx)
            else report_mismatch($sformatf("commit %0d index x%0d, expected x%0d",
                                           n_commits, commit_wr_idx, exp.idx));
            assert (commit_wr_data == exp.data)
            else report_mismatch($sformatf("commit %0d data %08h, expected %08h",
                                           n_commits, commit_wr_data, exp.data));
        end
        assert (pipeline_error_status == exp.status)
        else report_mismatch($sformatf("commit %0d status %0d, expected %0d",
                                       n_commits, pipeline_error_status, exp.status));
        n_commits++;
    endtask

    // outputs settle from mem/wb well before the falling edge
    always @(negedge clk) begin
        if (pipeline_completed_insts) begin
            check_commit();
        end else begin
            assert (!commit_wr_en && pipeline_error_status == NO_ERROR)
            else report_mismatch("write or status raised without a completed instruction");
        end
    end

    // ////////////////////
    // watchdog
    // ////////////////////

    initial begin
        wait (n_entries != 0);
        #((n_entries + 20) * CLK_PERIOD);
        $display("Simulation failed");
        $fatal(1, "watchdog expired before the stimulus run finished");
    end

endmodule

// File: hdl/pipeline_core.sv
// in-order rv32i integer pipeline

`timescale 1ns/10ps

module pipeline_core (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     inst_valid,
    input  core_pkg::xlen_t          inst,
    output logic                     commit_wr_en,
    output core_pkg::reg_idx_t       commit_wr_idx,
    output core_pkg::xlen_t          commit_wr_data,
    output logic                     pipeline_completed_insts,
    output core_pkg::exception_code_t pipeline_error_status
);
    import core_pkg::*;

    // stage registers and the comb packets feeding them
    if_id_t  if_id;
    id_ex_t  id_packet;
    id_ex_t  id_ex;
    ex_mem_t ex_packet;
    ex_mem_t ex_mem;
    ex_mem_t mem_wb;

    // regfile read side, driven by decode
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    xlen_t    rs1_value;
    xlen_t    rs2_value;

    logic [1:0] fwd_a;
    logic [1:0] fwd_b;

    // set once a wfi retires
    logic halted;
    logic wb_active;

    // ////////////////////
    // if/id
    // ////////////////////

    always_ff @(posedge clk) begin
        if (rst)
            if_id <= '{valid: 1'b0, inst: NOP_INST};
        else
            if_id <= '{valid: inst_valid, inst: inst};
    end

    // ////////////////////
    // decode
    // ////////////////////

    decoder i_decoder (
        .if_id     (if_id),
        .rs1_idx   (rs1_idx),
        .rs2_idx   (rs2_idx),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .id_packet (id_packet)
    );

    // written from mem/wb, write-through covers distance 3
    regfile i_regfile (
        .clk       (clk),
        .rs1_idx   (rs1_idx),
        .rs2_idx   (rs2_idx),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .wr_en     (commit_wr_en),
        .wr_idx    (commit_wr_idx),
        .wr_data   (commit_wr_data)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            id_ex.valid   <= 1'b0;
            id_ex.wr_en   <= 1'b0;
            id_ex.halt    <= 1'b0;
            id_ex.illegal <= 1'b0;
        end else begin
            id_ex <= id_packet;
        end
    end

    // ////////////////////
    // execute
    // ////////////////////

    forwarding_unit i_forwarding_unit (
        .id_ex  (id_ex),
        .ex_mem (ex_mem),
        .mem_wb (mem_wb),
        .fwd_a  (fwd_a),
        .fwd_b  (fwd_b)
    );

    ex_stage i_ex_stage (
        .id_ex     (id_ex),
        .ex_mem    (ex_mem),
        .mem_wb    (mem_wb),
        .fwd_a     (fwd_a),
        .fwd_b     (fwd_b),
        .ex_packet (ex_packet)
    );

    // ex/mem then mem/wb, mem stage itself is empty
    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem.valid   <= 1'b0;
            ex_mem.wr_en   <= 1'b0;
            ex_mem.halt    <= 1'b0;
            ex_mem.illegal <= 1'b0;
            mem_wb.valid   <= 1'b0;
            mem_wb.wr_en   <= 1'b0;
            mem_wb.halt    <= 1'b0;
            mem_wb.illegal <= 1'b0;
        end else begin
            ex_mem <= ex_packet;
            mem_wb <= ex_mem;
        end
    end

    // ////////////////////
    // writeback, monitor
    // ////////////////////

    always_ff @(posedge clk) begin
        if (rst)
            halted <= 1'b0;
        else if (mem_wb.valid && mem_wb.halt)
            halted <= 1'b1;
    end

    // nothing behind the wfi may retire
    assign wb_active = mem_wb.valid && !halted;

    assign commit_wr_en   = wb_active && mem_wb.wr_en;
    assign commit_wr_idx  = mem_wb.dest_reg_idx;
    assign commit_wr_data = mem_wb.result;

    assign pipeline_completed_insts = wb_active;

    // illegal outranks halt
    always_comb begin
        if (wb_active && mem_wb.illegal)
            pipeline_error_status = ILLEGAL_INST;
        else if (wb_active && mem_wb.halt)
            pipeline_error_status = HALTED_ON_WFI;
        else
            pipeline_error_status = NO_ERROR;
    end

endmodule

// File: hdl/ex_stage.sv
// execute stage alu

`timescale 1ns/10ps

module ex_stage (
    input  core_pkg::id_ex_t  id_ex,
    input  core_pkg::ex_mem_t ex_mem,
    input  core_pkg::ex_mem_t mem_wb,
    input  logic [1:0]        fwd_a,
    input  logic [1:0]        fwd_b,
    output core_pkg::ex_mem_t ex_packet
);
    import core_pkg::*;

    xlen_t opa;
    xlen_t rs2_fwd;
    xlen_t opb;
    xlen_t alu_result;

    // regfile value or a younger result still in flight
    function automatic xlen_t select_operand(input logic [1:0] sel, input xlen_t reg_value);
        case (sel)
            FWD_EX_MEM: return ex_mem.result;
            FWD_MEM_WB: return mem_wb.result;
            default:    return reg_value;
        endcase
    endfunction

    // ////////////////////
    // operands
    // ////////////////////

    always_comb begin
        opa     = select_operand(fwd_a, id_ex.rs1_value);
        rs2_fwd = select_operand(fwd_b, id_ex.rs2_value);
        // immediate overrides rs2 for i-type and lui
        opb     = id_ex.use_imm ? id_ex.imm : rs2_fwd;
    end

    // ////////////////////
    // alu
    // ////////////////////

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:    alu_result = opa + opb;
            ALU_SUB:    alu_result = opa - opb;
            ALU_AND:    alu_result = opa & opb;
            ALU_OR:     alu_result = opa | opb;
            ALU_XOR:    alu_result = opa ^ opb;
            ALU_PASS_B: alu_result = opb;
            default:    alu_result = '0;
        endcase
    end

    // control rides along unchanged
    always_comb begin
        ex_packet.valid        = id_ex.valid;
        ex_packet.result       = alu_result;
        ex_packet.dest_reg_idx = id_ex.dest_reg_idx;
        ex_packet.wr_en        = id_ex.wr_en;
        ex_packet.halt         = id_ex.halt;
        ex_packet.illegal      = id_ex.illegal;
    end

endmodule

// File: hdl/forwarding_unit.sv
// execute operand forwarding select

`timescale 1ns/10ps

module forwarding_unit (
    input  core_pkg::id_ex_t  id_ex,
    input  core_pkg::ex_mem_t ex_mem,
    input  core_pkg::ex_mem_t mem_wb,
    output logic [1:0]        fwd_a,
    output logic [1:0]        fwd_b
);
    import core_pkg::*;

    // true when pkt will write idx
    function automatic logic writes_reg(input ex_mem_t pkt, input reg_idx_t idx);
        return pkt.valid && pkt.wr_en && (pkt.dest_reg_idx == idx);
    endfunction

    // nearest older writer wins, ex/mem checked first
    function automatic logic [1:0] pick_source(input reg_idx_t idx);
        if (idx == '0)
            return FWD_ID_EX;
        else if (writes_reg(ex_mem, idx))
            return FWD_EX_MEM;
        else if (writes_reg(mem_wb, idx))
            return FWD_MEM_WB;
        else
            return FWD_ID_EX;
    endfunction

    always_comb begin
        fwd_a = pick_source(id_ex.rs1_idx);
        fwd_b = pick_source(id_ex.rs2_idx);
    end

endmodule

// File: hdl/decoder.sv
// rv32i subset decoder

`timescale 1ns/10ps

module decoder (
    input  core_pkg::if_id_t   if_id,
    output core_pkg::reg_idx_t rs1_idx,
    output core_pkg::reg_idx_t rs2_idx,
    input  core_pkg::xlen_t    rs1_value,
    input  core_pkg::xlen_t    rs2_value,
    output core_pkg::id_ex_t   id_packet
);
    import core_pkg::*;

    // funct fields of the supported ops
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [6:0] F7_BASE = 7'h00;
    localparam logic [6:0] F7_ALT  = 7'h20;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rd;
    xlen_t      imm_i;
    xlen_t      imm_u;

    logic    legal;
    logic    is_wfi;
    logic    use_imm;
    alu_op_t alu_op;

    // ////////////////////
    // field split
    // ////////////////////

    assign opcode  = if_id.inst[6:0];
    assign rd      = if_id.inst[11:7];
    assign funct3  = if_id.inst[14:12];
    assign rs1_idx = if_id.inst[19:15];
    assign rs2_idx = if_id.inst[24:20];
    assign funct7  = if_id.inst[31:25];

    // sign-extended i imm, upper u imm
    assign imm_i = {{20{if_id.inst[31]}}, if_id.inst[31:20]};
    assign imm_u = {if_id.inst[31:12], 12'b0};

    // ////////////////////
    // classify
    // ////////////////////

    always_comb begin
        legal   = 1'b0;
        is_wfi  = 1'b0;
        use_imm = 1'b0;
        alu_op  = ALU_ADD;
        case (opcode)
            OP_REG: begin
                legal = 1'b1;
                case ({funct7, funct3})
                    {F7_BASE, F3_ADD}: alu_op = ALU_ADD;
                    {F7_ALT, F3_ADD}:  alu_op = ALU_SUB;
                    {F7_BASE, F3_XOR}: alu_op = ALU_XOR;
                    {F7_BASE, F3_OR}:  alu_op = ALU_OR;
                    {F7_BASE, F3_AND}: alu_op = ALU_AND;
                    default:           legal  = 1'b0;
                endcase
            end
            OP_IMM: begin
                legal   = 1'b1;
                use_imm = 1'b1;
                case (funct3)
                    F3_ADD:  alu_op = ALU_ADD;
                    F3_XOR:  alu_op = ALU_XOR;
                    F3_OR:   alu_op = ALU_OR;
                    F3_AND:  alu_op = ALU_AND;
                    // slti, shifts etc. not supported
                    default: legal  = 1'b0;
                endcase
            end
            OP_LUI: begin
                legal   = 1'b1;
                use_imm = 1'b1;
                alu_op  = ALU_PASS_B;
            end
            // only the exact wfi word is accepted
            OP_SYSTEM: is_wfi = (if_id.inst == WFI_INST);
            default: ;
        endcase
    end

    // ////////////////////
    // packet build
    // ////////////////////

    always_comb begin
        id_packet.valid        = if_id.valid;
        id_packet.rs1_idx      = rs1_idx;
        id_packet.rs2_idx      = rs2_idx;
        id_packet.rs1_value    = rs1_value;
        id_packet.rs2_value    = rs2_value;
        id_packet.imm          = (opcode == OP_LUI) ? imm_u : imm_i;
        id_packet.use_imm      = use_imm;
        id_packet.alu_op       = alu_op;
        id_packet.dest_reg_idx = rd;
        // control bits qualified by valid so bubbles stay inert
        id_packet.wr_en        = if_id.valid && legal && (rd != '0);
        id_packet.halt         = if_id.valid && is_wfi;
        id_packet.illegal      = if_id.valid && !legal && !is_wfi;
    end

endmodule

// File: hdl/regfile.sv
// integer register file

`timescale 1ns/10ps

module regfile (
    input  logic              clk,
    input  core_pkg::reg_idx_t rs1_idx,
    input  core_pkg::reg_idx_t rs2_idx,
    output core_pkg::xlen_t    rs1_value,
    output core_pkg::xlen_t    rs2_value,
    input  logic              wr_en,
    input  core_pkg::reg_idx_t wr_idx,
    input  core_pkg::xlen_t    wr_data
);
    import core_pkg::*;

    // x1..x31, x0 never stored
    xlen_t regs [1:31];

    // x0 reads zero, same-cycle write bypasses the array
    function automatic xlen_t read_port(input reg_idx_t idx);
        if (idx == '0)
            return '0;
        else if (wr_en && (wr_idx == idx))
            return wr_data;
        else
            return regs[idx];
    endfunction

    // reads follow the write port and the array, not only the index
    always_comb begin
        rs1_value = read_port(rs1_idx);
        rs2_value = read_port(rs2_idx);
    end

    // writes to x0 dropped
    always_ff @(posedge clk) begin
        if (wr_en && (wr_idx != '0))
            regs[wr_idx] <= wr_data;
    end

endmodule

// File: hdl/core_pkg.sv
// rv32i core shared definitions

package core_pkg;

    // ////////////////////
    // base types
    // ////////////////////

    localparam int XLEN = 32;

    // data or instruction word
    typedef logic [XLEN-1:0] xlen_t;
    // architectural register index
    typedef logic [4:0]      reg_idx_t;
    typedef logic [2:0]      alu_op_t;
    typedef logic [1:0]      exception_code_t;

    // alu function codes
    localparam alu_op_t ALU_ADD    = 3'd0;
    localparam alu_op_t ALU_SUB    = 3'd1;
    localparam alu_op_t ALU_AND    = 3'd2;
    localparam alu_op_t ALU_OR     = 3'd3;
    localparam alu_op_t ALU_XOR    = 3'd4;
    // lui passes the u immediate straight through
    localparam alu_op_t ALU_PASS_B = 3'd5;

    // monitor status
    localparam exception_code_t NO_ERROR      = 2'd0;
    localparam exception_code_t ILLEGAL_INST  = 2'd1;
    localparam exception_code_t HALTED_ON_WFI = 2'd2;

    // major opcodes
    localparam logic [6:0] OP_REG    = 7'h33;
    localparam logic [6:0] OP_IMM    = 7'h13;
    localparam logic [6:0] OP_LUI    = 7'h37;
    localparam logic [6:0] OP_SYSTEM = 7'h73;

    localparam xlen_t WFI_INST = 32'h10500073;
    // addi x0, x0, 0
    localparam xlen_t NOP_INST = 32'h00000013;

    // operand source select for execute
    localparam logic [1:0] FWD_ID_EX  = 2'd0;
    localparam logic [1:0] FWD_EX_MEM = 2'd1;
    localparam logic [1:0] FWD_MEM_WB = 2'd2;

    // ////////////////////
    // pipeline packets
    // ////////////////////

    typedef struct packed {
        logic  valid;
        xlen_t inst;
    } if_id_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rs1_idx;
        reg_idx_t rs2_idx;
        xlen_t    rs1_value;
        xlen_t    rs2_value;
        xlen_t    imm;
        logic     use_imm;
        alu_op_t  alu_op;
        reg_idx_t dest_reg_idx;
        logic     wr_en;
        logic     halt;
        logic     illegal;
    } id_ex_t;

    // used for both ex/mem and mem/wb
    typedef struct packed {
        logic     valid;
        xlen_t    result;
        reg_idx_t dest_reg_idx;
        logic     wr_en;
        logic     halt;
        logic     illegal;
    } ex_mem_t;

endpackage
